//--- logic/battle_apb_regs.sv
`default_nettype none

`include "battle_consts.svh"

module battle_apb_regs (
  input  logic                       Clk,
  input  logic                       rst_n,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [4:0]                 paddr,
  input  logic [31:0]                pwdata,
  output logic [31:0]                prdata,
  output logic                       pready,
  output logic                       pslverr,
  output logic                       start,
  output logic                       key_valid,
  output logic [7:0]                 keycode,
  output battle_pkg::team_t          player_team,
  output battle_pkg::team_t          enemy_team,
  input  battle_pkg::battle_status_t status,
  input  logic [7:0]                 player_hp,
  input  logic [7:0]                 enemy_hp
);

  logic wr;
  logic mapped;

  assign wr     = psel && penable && pwrite;
  assign mapped = (paddr == `REG_CTRL) || (paddr == `REG_TEAM) || (paddr == `REG_KEY) ||
                  (paddr == `REG_STATUS) || (paddr == `REG_HP);

  // zero wait states
  assign pready  = 1'b1;
  assign pslverr = psel && penable && !mapped;

  always_comb
  begin
    case (paddr)
      `REG_TEAM:   prdata = {7'd0, enemy_team, 7'd0, player_team};
      `REG_KEY:    prdata = {24'd0, keycode};
      `REG_STATUS: prdata = {21'd0, status};
      `REG_HP:     prdata = {16'd0, enemy_hp, player_hp};
      default:     prdata = 32'd0;
    endcase
  end

  always_ff @(posedge Clk)
  begin
    if (!rst_n)
    begin
      start       <= 1'b0;
      key_valid   <= 1'b0;
      keycode     <= 8'd0;
      player_team <= '0;
      enemy_team  <= '0;
    end
    else
    begin
      // ctrl and key writes become single cycle strobes
      start     <= wr && (paddr == `REG_CTRL) && pwdata[0];
      key_valid <= wr && (paddr == `REG_KEY);
      if (wr && paddr == `REG_KEY)
        keycode <= pwdata[7:0];
      if (wr && paddr == `REG_TEAM)
      begin
        player_team <= pwdata[8:0];
        enemy_team  <= pwdata[24:16];
      end
    end
  end

  a_penable_in_psel: assert property (@(posedge Clk) disable iff (!rst_n)
    penable |-> psel);

endmodule

`default_nettype wire

//--- logic/battle_consts.svh
`ifndef BATTLE_CONSTS_SVH
`define BATTLE_CONSTS_SVH

// host key codes
`define KEY_W     8'h1A
`define KEY_A     8'h04
`define KEY_S     8'h16
`define KEY_D     8'h07
`define KEY_ENTER 8'h28

// apb register map
`define REG_CTRL   5'h00
`define REG_TEAM   5'h04
`define REG_KEY    5'h08
`define REG_STATUS 5'h0C
`define REG_HP     5'h10

`define BAR_HEIGHT 4

// stat formula, value = base + step * index
`define HP_BASE  40
`define HP_STEP  8
`define ATK_BASE 10
`define ATK_STEP 3
`define DEF_BASE 6
`define DEF_STEP 2
`define POW_BASE 6
`define POW_STEP 4

`endif

//--- logic/battle_fsm.sv
`default_nettype none

`include "battle_consts.svh"

module battle_fsm (
  input  logic                       Clk,
  input  logic                       rst_n,
  input  logic                       start,
  input  logic                       key_valid,
  input  logic [7:0]                 keycode,
  input  battle_pkg::team_t          player_team,
  input  battle_pkg::team_t          enemy_team,
  output battle_pkg::species_t       species_a,
  output battle_pkg::species_t       species_b,
  output logic [2:0]                 move_a,
  output logic [2:0]                 move_b,
  input  battle_pkg::mon_stats_t     stats_a,
  input  battle_pkg::mon_stats_t     stats_b,
  input  battle_pkg::move_stats_t    move_stats_a,
  input  battle_pkg::move_stats_t    move_stats_b,
  input  logic [7:0]                 damage,
  output battle_pkg::mon_stats_t     attacker,
  output battle_pkg::mon_stats_t     defender,
  output logic [7:0]                 power,
  output battle_pkg::battle_status_t status,
  output logic [7:0]                 player_hp,
  output logic [7:0]                 enemy_hp,
  output logic [7:0]                 player_max_hp,
  output logic [7:0]                 enemy_max_hp
);

  battle_pkg::battle_state_e state;
  battle_pkg::battle_state_e next_state;
  logic [7:0] hp_p [3];
  logic [7:0] hp_e [3];
  logic [7:0] max_p [3];
  logic [7:0] max_e [3];
  logic [1:0] cur_mon;
  logic [1:0] opp_mon;
  logic [1:0] move_index;
  logic [1:0] load_cnt;
  logic [7:0] turn;
  logic       done;
  logic       result;
  logic       strike;
  logic       player_strikes;
  logic       attacker_alive;
  logic [1:0] p_next;
  logic [1:0] e_next;
  logic       p_out;
  logic       e_out;

  function automatic battle_pkg::species_t slot_of(battle_pkg::team_t t, logic [1:0] i);
    case (i)
      2'd1:    return t.s1;
      2'd2:    return t.s2;
      default: return t.s0;
    endcase
  endfunction

  // next living slot after cur, 3 when none is left
  function automatic logic [1:0] next_living(logic [7:0] hp [3], logic [1:0] cur);
    logic [1:0] nxt;
    nxt = 2'd3;
    for (int i = 2; i >= 0; i--)
    begin
      if (i > int'(cur) && hp[i] != 8'd0)
        nxt = 2'(i);
    end
    return nxt;
  endfunction

  // during load the table walks the team slots
  assign species_a = slot_of(player_team, (state == battle_pkg::st_load) ? load_cnt : cur_mon);
  assign species_b = slot_of(enemy_team, (state == battle_pkg::st_load) ? load_cnt : opp_mon);
  assign move_a    = stats_a.moves[move_index];
  // enemy cycles through its slots by turn
  assign move_b    = stats_b.moves[turn[1:0]];

  // tie on speed goes to the enemy
  assign strike = (state == battle_pkg::st_first_strike) ||
                  (state == battle_pkg::st_second_strike);
  assign player_strikes = (state == battle_pkg::st_first_strike) ?
                          (stats_a.speed > stats_b.speed) : (stats_a.speed <= stats_b.speed);
  assign attacker = player_strikes ? stats_a : stats_b;
  assign defender = player_strikes ? stats_b : stats_a;
  assign power    = player_strikes ? move_stats_a.power : move_stats_b.power;
  assign attacker_alive = player_strikes ? (hp_p[cur_mon] != 8'd0) : (hp_e[opp_mon] != 8'd0);

  assign p_next = next_living(hp_p, cur_mon);
  assign e_next = next_living(hp_e, opp_mon);
  assign p_out  = (hp_p[cur_mon] == 8'd0) && (p_next == 2'd3);
  assign e_out  = (hp_e[opp_mon] == 8'd0) && (e_next == 2'd3);

  always_comb
  begin
    next_state = state;
    case (state)
      battle_pkg::st_idle:
        if (start)
          next_state = battle_pkg::st_load;
      battle_pkg::st_load:
        if (load_cnt == 2'd2)
          next_state = battle_pkg::st_select;
      battle_pkg::st_select:
        if (key_valid && keycode == `KEY_ENTER)
          next_state = battle_pkg::st_first_strike;
      battle_pkg::st_first_strike:
        next_state = battle_pkg::st_second_strike;
      battle_pkg::st_second_strike:
        next_state = battle_pkg::st_end_turn;
      battle_pkg::st_end_turn:
      begin
        // player loss wins the tie
        if (p_out)
          next_state = battle_pkg::st_lose;
        else if (e_out)
          next_state = battle_pkg::st_win;
        else
          next_state = battle_pkg::st_select;
      end
      default:
        next_state = battle_pkg::st_idle;
    endcase
  end

  always_ff @(posedge Clk)
  begin
    if (!rst_n)
    begin
      state      <= battle_pkg::st_idle;
      cur_mon    <= 2'd0;
      opp_mon    <= 2'd0;
      move_index <= 2'd0;
      load_cnt   <= 2'd0;
      turn       <= 8'd0;
      done       <= 1'b0;
      result     <= 1'b0;
      for (int i = 0; i < 3; i++)
      begin
        hp_p[i]  <= 8'd0;
        hp_e[i]  <= 8'd0;
        max_p[i] <= 8'd0;
        max_e[i] <= 8'd0;
      end
    end
    else
    begin
      state <= next_state;
      case (state)
        battle_pkg::st_idle:
          if (start)
          begin
            done       <= 1'b0;
            result     <= 1'b0;
            load_cnt   <= 2'd0;
            cur_mon    <= 2'd0;
            opp_mon    <= 2'd0;
            move_index <= 2'd0;
            turn       <= 8'd0;
          end
        battle_pkg::st_load:
        begin
          hp_p[load_cnt]  <= stats_a.max_hp;
          max_p[load_cnt] <= stats_a.max_hp;
          hp_e[load_cnt]  <= stats_b.max_hp;
          max_e[load_cnt] <= stats_b.max_hp;
          load_cnt        <= load_cnt + 2'd1;
        end
        battle_pkg::st_select:
          if (key_valid)
          begin
            // cursor on a 2x2 grid, bit 1 is the row
            case (keycode)
              `KEY_W: if (move_index[1])  move_index <= move_index - 2'd2;
              `KEY_S: if (!move_index[1]) move_index <= move_index + 2'd2;
              `KEY_A: if (move_index[0])  move_index <= move_index - 2'd1;
              `KEY_D: if (!move_index[0]) move_index <= move_index + 2'd1;
              default: ;
            endcase
          end
        battle_pkg::st_first_strike, battle_pkg::st_second_strike:
          if (attacker_alive)
          begin
            if (player_strikes)
              hp_e[opp_mon] <= (damage >= hp_e[opp_mon]) ? 8'd0 : hp_e[opp_mon] - damage;
            else
              hp_p[cur_mon] <= (damage >= hp_p[cur_mon]) ? 8'd0 : hp_p[cur_mon] - damage;
          end
        battle_pkg::st_end_turn:
        begin
          turn <= turn + 8'd1;
          if (hp_p[cur_mon] == 8'd0 && p_next != 2'd3)
            cur_mon <= p_next;
          if (hp_e[opp_mon] == 8'd0 && e_next != 2'd3)
            opp_mon <= e_next;
        end
        battle_pkg::st_win:
        begin
          done   <= 1'b1;
          result <= 1'b1;
        end
        battle_pkg::st_lose:
        begin
          done   <= 1'b1;
          result <= 1'b0;
        end
        default: ;
      endcase
    end
  end

  assign status.state      = state;
  assign status.done       = done;
  assign status.result     = result;
  assign status.cur_mon    = cur_mon;
  assign status.opp_mon    = opp_mon;
  assign status.move_index = move_index;

  assign player_hp     = hp_p[cur_mon];
  assign enemy_hp      = hp_e[opp_mon];
  assign player_max_hp = max_p[cur_mon];
  assign enemy_max_hp  = max_e[opp_mon];

  // hp only grows when a team is loaded
  for (genvar g = 0; g < 3; g++)
  begin : g_hp_check
    a_hp_no_rise: assert property (@(posedge Clk) disable iff (!rst_n)
      state != battle_pkg::st_load |=>
        (hp_p[g] <= $past(hp_p[g])) && (hp_e[g] <= $past(hp_e[g])));
  end

  a_damage_nonzero: assert property (@(posedge Clk) disable iff (!rst_n)
    strike |-> damage != 8'd0);

endmodule

`default_nettype wire

//--- logic/battle_info.sv
`default_nettype none

`include "battle_consts.svh"

module battle_info #(
  parameter int X0 = 0,
  parameter int Y0 = 0
) (
  input  logic                  Clk,
  input  logic                  rst_n,
  input  video_pkg::beam_pos_t  beam,
  input  logic [7:0]            cur_hp,
  input  logic [7:0]            max_hp,
  output video_pkg::bar_pixel_t pixel
);

  logic [10:0] bx;
  logic [10:0] by;
  logic [10:0] fill_end;
  logic [10:0] frame_end;
  logic        in_rows;
  logic        in_fill;
  logic        in_frame;
  video_pkg::bar_pixel_t next_pixel;

  assign bx = {1'b0, beam.x};
  assign by = {1'b0, beam.y};

  // one column per 4 hp, end columns exclusive
  assign fill_end  = 11'(X0) + {5'd0, cur_hp[7:2]};
  assign frame_end = 11'(X0) + {5'd0, max_hp[7:2]};

  assign in_rows  = (by >= 11'(Y0)) && (by < 11'(Y0 + `BAR_HEIGHT));
  assign in_fill  = in_rows && (bx >= 11'(X0)) && (bx < fill_end);
  assign in_frame = in_rows && (bx >= 11'(X0)) && (bx < frame_end);

  always_comb
  begin
    next_pixel = '0;
    if (in_fill)
    begin
      next_pixel.on = 1'b1;
      if ({cur_hp, 1'b0} > {1'b0, max_hp})
        next_pixel.g = 8'hFF;
      else if ({cur_hp, 2'b00} > {2'b00, max_hp})
      begin
        next_pixel.r = 8'hFF;
        next_pixel.g = 8'hFF;
      end
      else
        next_pixel.r = 8'hFF;
    end
    else if (in_frame)
    begin
      // lost hp shows as gray
      next_pixel = '{r: 8'h80, g: 8'h80, b: 8'h80, on: 1'b1};
    end
  end

  always_ff @(posedge Clk)
  begin
    if (!rst_n)
      pixel <= '0;
    else
      pixel <= next_pixel;
  end

endmodule

`default_nettype wire

//--- logic/battle_pkg.sv
`default_nettype none

package battle_pkg;

  typedef logic [2:0] species_t;

  // slot 0 sits in the low bits
  typedef struct packed {
    species_t s2;
    species_t s1;
    species_t s0;
  } team_t;

  typedef struct packed {
    logic [7:0]      max_hp;
    logic [7:0]      atk;
    logic [7:0]      def;
    logic [7:0]      speed;
    logic [3:0][2:0] moves;
  } mon_stats_t;

  typedef struct packed {
    logic [7:0] power;
  } move_stats_t;

  typedef enum logic [2:0] {
    st_idle,
    st_load,
    st_select,
    st_first_strike,
    st_second_strike,
    st_end_turn,
    st_win,
    st_lose
  } battle_state_e;

  // result is 1 for a player win
  typedef struct packed {
    battle_state_e state;
    logic          done;
    logic          result;
    logic [1:0]    cur_mon;
    logic [1:0]    opp_mon;
    logic [1:0]    move_index;
  } battle_status_t;

endpackage

`default_nettype wire

//--- logic/battle_top.sv
`default_nettype none

module battle_top (
  input  logic                  Clk,
  input  logic                  rst_n,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [4:0]            paddr,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  input  video_pkg::beam_pos_t  beam,
  output video_pkg::bar_pixel_t bar_pixel
);

  logic                       start;
  logic                       key_valid;
  logic [7:0]                 keycode;
  battle_pkg::team_t          player_team;
  battle_pkg::team_t          enemy_team;
  battle_pkg::battle_status_t status;
  logic [7:0]                 player_hp;
  logic [7:0]                 enemy_hp;
  logic [7:0]                 player_max_hp;
  logic [7:0]                 enemy_max_hp;
  battle_pkg::species_t       species_a;
  battle_pkg::species_t       species_b;
  logic [2:0]                 move_a;
  logic [2:0]                 move_b;
  battle_pkg::mon_stats_t     stats_a;
  battle_pkg::mon_stats_t     stats_b;
  battle_pkg::move_stats_t    move_stats_a;
  battle_pkg::move_stats_t    move_stats_b;
  battle_pkg::mon_stats_t     attacker;
  battle_pkg::mon_stats_t     defender;
  logic [7:0]                 power;
  logic [7:0]                 damage;
  video_pkg::bar_pixel_t      player_pixel;
  video_pkg::bar_pixel_t      enemy_pixel;

  battle_apb_regs regs_inst (
    .Clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .start, .key_valid, .keycode, .player_team, .enemy_team,
    .status, .player_hp, .enemy_hp
  );

  battle_fsm fsm_inst (
    .Clk, .rst_n, .start, .key_valid, .keycode, .player_team, .enemy_team,
    .species_a, .species_b, .move_a, .move_b,
    .stats_a, .stats_b, .move_stats_a, .move_stats_b, .damage,
    .attacker, .defender, .power,
    .status, .player_hp, .enemy_hp, .player_max_hp, .enemy_max_hp
  );

  stats_rom rom_inst (
    .species_a, .species_b, .move_a, .move_b,
    .stats_a, .stats_b, .move_stats_a, .move_stats_b
  );

  damage_calc calc_inst (
    .attacker, .defender, .power, .damage
  );

  battle_info #(.X0(240), .Y0(140)) player_info_inst (
    .Clk, .rst_n, .beam, .cur_hp(player_hp), .max_hp(player_max_hp), .pixel(player_pixel)
  );

  battle_info #(.X0(90), .Y0(280)) enemy_info_inst (
    .Clk, .rst_n, .beam, .cur_hp(enemy_hp), .max_hp(enemy_max_hp), .pixel(enemy_pixel)
  );

  // player bar drawn on top
  assign bar_pixel = player_pixel.on ? player_pixel : enemy_pixel;

endmodule

`default_nettype wire

//--- logic/damage_calc.sv
`default_nettype none

module damage_calc (
  input  battle_pkg::mon_stats_t attacker,
  input  battle_pkg::mon_stats_t defender,
  input  logic [7:0]             power,
  output logic [7:0]             damage
);

  // wide enough for 255 + 255 - 255 and for negatives
  logic signed [10:0] raw;

  assign raw = $signed({3'd0, power}) + $signed({3'd0, attacker.atk})
             - $signed({3'd0, defender.def});

  always_comb
  begin
    if (raw < 11'sd1)
    begin
      // every hit does at least one point
      damage = 8'd1;
    end
    else if (raw > 11'sd255)
    begin
      damage = 8'd255;
    end
    else
    begin
      damage = raw[7:0];
    end
  end

endmodule

`default_nettype wire

//--- logic/stats_rom.sv
`default_nettype none

`include "battle_consts.svh"

module stats_rom (
  input  battle_pkg::species_t    species_a,
  input  battle_pkg::species_t    species_b,
  input  logic [2:0]              move_a,
  input  logic [2:0]              move_b,
  output battle_pkg::mon_stats_t  stats_a,
  output battle_pkg::mon_stats_t  stats_b,
  output battle_pkg::move_stats_t move_stats_a,
  output battle_pkg::move_stats_t move_stats_b
);

  function automatic battle_pkg::mon_stats_t species_stats(battle_pkg::species_t n);
    battle_pkg::mon_stats_t s;
    s.max_hp = 8'(`HP_BASE + `HP_STEP * n);
    s.atk    = 8'(`ATK_BASE + `ATK_STEP * n);
    s.def    = 8'(`DEF_BASE + `DEF_STEP * n);
    // speed is 7n mod 8, so it scrambles the order
    s.speed  = {5'd0, 3'(7 * n)};
    for (int k = 0; k < 4; k++)
    begin
      // wraps mod 8
      s.moves[k] = 3'(n + k);
    end
    return s;
  endfunction

  function automatic battle_pkg::move_stats_t move_stats(logic [2:0] m);
    battle_pkg::move_stats_t ms;
    ms.power = 8'(`POW_BASE + `POW_STEP * m);
    return ms;
  endfunction

  // player side on port a, enemy side on port b
  always_comb
  begin
    stats_a      = species_stats(species_a);
    stats_b      = species_stats(species_b);
    move_stats_a = move_stats(move_a);
    move_stats_b = move_stats(move_b);
  end

endmodule

`default_nettype wire

//--- logic/video_pkg.sv
`default_nettype none

package video_pkg;

  // current beam position from the display timing
  typedef struct packed {
    logic [9:0] x;
    logic [9:0] y;
  } beam_pos_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    logic       on;
  } bar_pixel_t;

endpackage

`default_nettype wire

//--- project.f
+incdir+logic
logic/battle_pkg.sv
logic/video_pkg.sv
logic/stats_rom.sv
logic/damage_calc.sv
logic/battle_fsm.sv
logic/battle_info.sv
logic/battle_apb_regs.sv
logic/battle_top.sv
tb/battle_model.sv
tb/battle_tb.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
  --top-module battle_tb -f project.f -o battle_sim \
  && ./obj_dir/battle_sim | tee /dev/stderr | grep -F "*** TEST PASSED ***" > /dev/null \
  && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }

//--- tb/battle_model.sv
`default_nettype none

`include "battle_consts.svh"

package battle_model;

  // one team as the reference sees it, slot 0 in the low bits
  typedef struct packed {
    logic [2:0][2:0] species;
    logic [2:0][7:0] hp;
    logic [1:0]      act;
  } side_t;

  typedef struct packed {
    side_t      p;
    side_t      e;
    logic [1:0] cursor;
    logic [7:0] turn;
    logic       over;
    logic       win;
  } game_t;

  function automatic int max_hp_of(int n);
    return `HP_BASE + `HP_STEP * n;
  endfunction

  function automatic int atk_of(int n);
    return `ATK_BASE + `ATK_STEP * n;
  endfunction

  function automatic int def_of(int n);
    return `DEF_BASE + `DEF_STEP * n;
  endfunction

  function automatic int speed_of(int n);
    return (7 * n) % 8;
  endfunction

  function automatic int move_of(int n, int k);
    return (n + k) % 8;
  endfunction

  function automatic int power_of(int m);
    return `POW_BASE + `POW_STEP * m;
  endfunction

  function automatic int hit(int atk_sp, int def_sp, int move_id);
    int d;
    d = power_of(move_id) + atk_of(atk_sp) - def_of(def_sp);
    if (d < 1)
      d = 1;
    if (d > 255)
      d = 255;
    return d;
  endfunction

  function automatic logic [7:0] take_hit(logic [7:0] hp, int dmg);
    if (int'(hp) <= dmg)
      return 8'd0;
    return 8'(int'(hp) - dmg);
  endfunction

  function automatic side_t new_side(logic [8:0] team);
    side_t s;
    s.species = team;
    s.act = 2'd0;
    for (int k = 0; k < 3; k++)
      s.hp[k] = 8'(max_hp_of(int'(s.species[k])));
    return s;
  endfunction

  function automatic game_t new_game(logic [8:0] player_team, logic [8:0] enemy_team);
    game_t g;
    g = '0;
    g.p = new_side(player_team);
    g.e = new_side(enemy_team);
    return g;
  endfunction

  // 3 means nobody left
  function automatic int next_slot(side_t s);
    for (int i = int'(s.act) + 1; i < 3; i++)
      if (s.hp[i] != 8'd0)
        return i;
    return 3;
  endfunction

  function automatic logic [1:0] move_cursor(logic [1:0] cur, logic [7:0] key);
    int c;
    c = int'(cur);
    if (key == `KEY_W && c >= 2)
      c = c - 2;
    else if (key == `KEY_S && c < 2)
      c = c + 2;
    else if (key == `KEY_A && c % 2 == 1)
      c = c - 1;
    else if (key == `KEY_D && c % 2 == 0)
      c = c + 1;
    return 2'(c);
  endfunction

  function automatic game_t resolve_turn(game_t g);
    game_t r;
    int    ps;
    int    es;
    int    pmove;
    int    emove;
    int    pn;
    int    en;
    logic  pfirst;
    logic  p_strikes;
    logic  p_out;
    logic  e_out;
    r = g;
    ps = int'(r.p.species[r.p.act]);
    es = int'(r.e.species[r.e.act]);
    pmove = move_of(ps, int'(r.cursor));
    emove = move_of(es, int'(r.turn[1:0]));
    // enemy goes first on equal speed
    pfirst = speed_of(ps) > speed_of(es);
    for (int i = 0; i < 2; i++)
    begin
      p_strikes = (i == 0) ? pfirst : !pfirst;
      if (p_strikes && r.p.hp[r.p.act] != 8'd0)
        r.e.hp[r.e.act] = take_hit(r.e.hp[r.e.act], hit(ps, es, pmove));
      else if (!p_strikes && r.e.hp[r.e.act] != 8'd0)
        r.p.hp[r.p.act] = take_hit(r.p.hp[r.p.act], hit(es, ps, emove));
    end
    r.turn = r.turn + 8'd1;
    pn = next_slot(r.p);
    en = next_slot(r.e);
    p_out = (r.p.hp[r.p.act] == 8'd0) && (pn == 3);
    e_out = (r.e.hp[r.e.act] == 8'd0) && (en == 3);
    if (r.p.hp[r.p.act] == 8'd0 && pn != 3)
      r.p.act = 2'(pn);
    if (r.e.hp[r.e.act] == 8'd0 && en != 3)
      r.e.act = 2'(en);
    if (p_out)
    begin
      r.over = 1'b1;
      r.win  = 1'b0;
    end
    else if (e_out)
    begin
      r.over = 1'b1;
      r.win  = 1'b1;
    end
    return r;
  endfunction

  // one hp bar, end columns exclusive
  function automatic video_pkg::bar_pixel_t panel_pixel(int x, int y, int x0, int y0,
                                                        int hp, int mx);
    video_pkg::bar_pixel_t px;
    px = '0;
    if (y >= y0 && y < y0 + `BAR_HEIGHT && x >= x0)
    begin
      if (x < x0 + hp / 4)
      begin
        px.on = 1'b1;
        if (2 * hp > mx)
          px.g = 8'hFF;
        else if (4 * hp > mx)
        begin
          px.r = 8'hFF;
          px.g = 8'hFF;
        end
        else
          px.r = 8'hFF;
      end
      else if (x < x0 + mx / 4)
      begin
        px.r  = 8'h80;
        px.g  = 8'h80;
        px.b  = 8'h80;
        px.on = 1'b1;
      end
    end
    return px;
  endfunction

endpackage

`default_nettype wire

//--- tb/battle_tb.sv
`default_nettype none

`include "battle_consts.svh"

module battle_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_BATTLES     = 10;
  localparam int MAX_TURNS       = 300;
  localparam int CYCLES_PER_TURN = 64;
  // three directed battles run besides the random ones
  localparam int TIMEOUT_CYCLES  = (NUM_BATTLES + 3) * MAX_TURNS * CYCLES_PER_TURN + 4000;
  localparam int PLAYER_X0 = 240;
  localparam int PLAYER_Y0 = 140;
  localparam int ENEMY_X0  = 90;
  localparam int ENEMY_Y0  = 280;

  logic                  Clk;
  logic                  rst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [4:0]            paddr;
  logic [31:0]           pwdata;
  logic [31:0]           prdata;
  logic                  pready;
  logic                  pslverr;
  video_pkg::beam_pos_t  beam;
  video_pkg::bar_pixel_t bar_pixel;

  int unsigned         lcg_state;
  int                  checks;
  int                  errors;
  int                  tests;
  int                  test_checks;
  int                  test_errors;
  int                  cycles = 0;
  battle_model::game_t game;

  battle_top battle_top_inst (
    .Clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .beam, .bar_pixel
  );

  always #4 Clk = ~Clk;

  always @(posedge Clk)
  begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  function automatic int unsigned rand_below(int unsigned n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return (lcg_state >> 16) % n;
  endfunction

  function automatic logic [7:0] random_key();
    case (rand_below(5))
      0:       return `KEY_W;
      1:       return `KEY_A;
      2:       return `KEY_S;
      3:       return `KEY_D;
      default: return 8'h2C;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond)
    else
    begin
      $display("Error: %s", what);
      errors++;
    end
  endtask

  task automatic begin_test();
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %0d checks, %0d errors", tests, name,
             checks - test_checks, errors - test_errors);
  endtask

  // called 1 ns after a rising edge, returns the same way
  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge Clk);
    #1 penable = 1'b1;
    @(posedge Clk);
    #1 psel = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [4:0] addr, output logic [31:0] data, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge Clk);
    #1 penable = 1'b1;
    #1 data = prdata;
    err = pslverr;
    check_value("pready", 32'(pready), 32'd1);
    @(posedge Clk);
    #1 psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_status(output battle_pkg::battle_status_t st);
    logic [31:0] d;
    logic        e;
    apb_read(`REG_STATUS, d, e);
    st = d[10:0];
  endtask

  task automatic start_battle();
    logic [8:0]                 pt;
    logic [8:0]                 et;
    battle_pkg::battle_status_t st;
    pt = 9'(rand_below(512));
    et = 9'(rand_below(512));
    game = battle_model::new_game(pt, et);
    apb_write(`REG_TEAM, {7'd0, et, 7'd0, pt});
    apb_write(`REG_CTRL, 32'd1);
    do
    begin
      read_status(st);
    end
    while (st.state != battle_pkg::st_select);
    check_value("status.done", 32'(st.done), 32'd0);
  endtask

  task automatic send_key(input logic [7:0] key);
    battle_pkg::battle_status_t st;
    apb_write(`REG_KEY, 32'(key));
    game.cursor = battle_model::move_cursor(game.cursor, key);
    read_status(st);
    check_value("status.move_index", 32'(st.move_index), 32'(game.cursor));
  endtask

  task automatic run_turn(input int num_keys, output battle_pkg::battle_status_t st);
    logic [31:0] d;
    logic        e;
    for (int i = 0; i < num_keys; i++)
      send_key(random_key());
    apb_write(`REG_KEY, 32'(`KEY_ENTER));
    game = battle_model::resolve_turn(game);
    do
    begin
      read_status(st);
    end
    while (st.state == battle_pkg::st_select);
    while (st.state != battle_pkg::st_select && !st.done)
      read_status(st);
    apb_read(`REG_HP, d, e);
    check_value("hp.player", 32'(d[7:0]), 32'(game.p.hp[game.p.act]));
    check_value("hp.enemy", 32'(d[15:8]), 32'(game.e.hp[game.e.act]));
    check_value("status.done", 32'(st.done), 32'(game.over));
  endtask

  task automatic run_battle(input int max_keys);
    battle_pkg::battle_status_t st;
    int                         turns;
    turns = 0;
    st = '0;
    while (!game.over && !st.done && turns < MAX_TURNS)
    begin
      run_turn(int'(rand_below(max_keys + 1)), st);
      turns++;
    end
    read_status(st);
    check_true(st.done && game.over, "battle did not end together with the model");
    check_value("status.state", 32'(st.state), 32'(battle_pkg::st_idle));
    check_value("status.result", 32'(st.result), 32'(game.win));
    check_value("status.cur_mon", 32'(st.cur_mon), 32'(game.p.act));
    check_value("status.opp_mon", 32'(st.opp_mon), 32'(game.e.act));
  endtask

  function automatic video_pkg::bar_pixel_t expected_pixel(int x, int y);
    video_pkg::bar_pixel_t pp;
    video_pkg::bar_pixel_t ep;
    int                    ps;
    int                    es;
    ps = int'(game.p.species[game.p.act]);
    es = int'(game.e.species[game.e.act]);
    pp = battle_model::panel_pixel(x, y, PLAYER_X0, PLAYER_Y0, int'(game.p.hp[game.p.act]),
                                   battle_model::max_hp_of(ps));
    ep = battle_model::panel_pixel(x, y, ENEMY_X0, ENEMY_Y0, int'(game.e.hp[game.e.act]),
                                   battle_model::max_hp_of(es));
    // player bar on top
    return pp.on ? pp : ep;
  endfunction

  task automatic check_pixel(input int x, input int y);
    video_pkg::bar_pixel_t exp;
    beam.x = 10'(x);
    beam.y = 10'(y);
    @(posedge Clk);
    #1 exp = expected_pixel(x, y);
    check_value("bar_pixel", 32'(bar_pixel), 32'(exp));
  endtask

  initial
  begin
    battle_pkg::battle_status_t st;
    battle_pkg::battle_status_t st_before;
    logic [31:0]                d;
    logic [31:0]                hp_before;
    logic                       e;
    logic [7:0]                 key;
    Clk       = 1'b0;
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = 5'd0;
    pwdata    = 32'd0;
    beam      = '0;
    lcg_state = 32'd46178;
    checks    = 0;
    errors    = 0;
    tests     = 0;
    game      = '0;
    repeat (2) @(posedge Clk);
    #1 rst_n = 1'b1;

    begin_test();
    read_status(st);
    check_value("status.state", 32'(st.state), 32'(battle_pkg::st_idle));
    check_value("status.done", 32'(st.done), 32'd0);
    apb_read(`REG_HP, d, e);
    check_true(!e, "read of the HP register raised pslverr");
    apb_read(5'h14, d, e);
    check_true(e, "read of unmapped address 0x14 gave no pslverr");
    apb_read(5'h1C, d, e);
    check_true(e, "read of unmapped address 0x1C gave no pslverr");
    end_test("reset and address decode");

    begin_test();
    start_battle();
    for (int i = 0; i < 4; i++)
      if (!game.over)
        run_turn(8, st);
    run_battle(2);
    end_test("cursor keys");

    begin_test();
    start_battle();
    run_battle(1);
    end_test("turn hp");

    begin_test();
    for (int b = 0; b < NUM_BATTLES; b++)
    begin
      start_battle();
      run_battle(3);
    end
    end_test("random battles");

    begin_test();
    start_battle();
    for (int i = 0; i < 2; i++)
      if (!game.over)
        run_turn(1, st);
    for (int i = 0; i < 48; i++)
      check_pixel(PLAYER_X0 - 4 + int'(rand_below(34)), PLAYER_Y0 - 2 + int'(rand_below(8)));
    for (int i = 0; i < 48; i++)
      check_pixel(ENEMY_X0 - 4 + int'(rand_below(34)), ENEMY_Y0 - 2 + int'(rand_below(8)));
    for (int i = 0; i < 32; i++)
      check_pixel(int'(rand_below(640)), int'(rand_below(480)));
    run_battle(1);
    end_test("bar pixels");

    begin_test();
    read_status(st_before);
    apb_read(`REG_HP, hp_before, e);
    for (int i = 0; i < 8; i++)
    begin
      key = (rand_below(2) == 0) ? `KEY_ENTER : random_key();
      apb_write(`REG_KEY, 32'(key));
    end
    read_status(st);
    check_value("status", 32'(st), 32'(st_before));
    apb_read(`REG_HP, d, e);
    check_value("hp", d, hp_before);
    end_test("idle keys");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
